// File: common/ooo_params_pkg.sv
`default_nettype none

package ooo_params_pkg;

    // Datapath and architectural registers
    localparam int xlen      = 32;
    localparam int num_regs  = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w   = $clog2(xlen);

    // Tags index reorder buffer entries
    localparam int rob_depth = 8;
    localparam int tag_w     = 3;

    // Reservation station slots
    localparam int rs_depth = 4;
    localparam int rs_idx_w = $clog2(rs_depth);

    // Multiply occupancy of the execution unit
    localparam int mul_cycles = 3;
    localparam int mul_cnt_w  = $clog2(mul_cycles);

endpackage

`default_nettype wire

// File: common/ooo_types_pkg.sv
`default_nettype none

package ooo_types_pkg;

    import ooo_params_pkg::*;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_slt = 4'd7,
        alu_mul = 4'd8
    } alu_op_e;

    // Decoded operation as seen at the issue port
    typedef struct packed {
        alu_op_e              op;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic                 use_imm;
        logic [xlen-1:0]      imm;
    } issue_op_t;

    // Value is only meaningful once ready is set
    typedef struct packed {
        logic             ready;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } operand_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  value;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        alu_op_e          op;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
    } exec_req_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      value;
    } commit_t;

endpackage

`default_nettype wire

// File: verilog/reg_alias_file.sv
`default_nettype none

module reg_alias_file
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic             itf,
    input  logic             rst_n,
    input  logic             issue_fire,
    input  issue_op_t        issue_op,
    input  logic [tag_w-1:0] alloc_tag,
    output logic [tag_w-1:0] lookup_tag1,
    output logic [tag_w-1:0] lookup_tag2,
    input  operand_t         lookup_opnd1,
    input  operand_t         lookup_opnd2,
    output operand_t         src1,
    output operand_t         src2,
    input  commit_t          commit,
    input  logic [tag_w-1:0] commit_tag
);

    logic [xlen-1:0]     regs      [num_regs];
    logic [tag_w-1:0]    alias_tag [num_regs];
    logic [num_regs-1:0] busy;

    // Pick the register value, the ROB's finished result, or a tag to wait on
    function automatic operand_t resolve(logic pending, logic [xlen-1:0] value,
                                         logic [tag_w-1:0] tag, operand_t lookup);
        operand_t o;
        if (!pending) begin
            o = '{ready: 1'b1, tag: '0, value: value};
        end else if (lookup.ready) begin
            o = '{ready: 1'b1, tag: tag, value: lookup.value};
        end else begin
            o = '{ready: 1'b0, tag: tag, value: '0};
        end
        return o;
    endfunction

    assign lookup_tag1 = alias_tag[issue_op.rs1];
    assign lookup_tag2 = alias_tag[issue_op.rs2];

    always_comb begin
        src1 = resolve(busy[issue_op.rs1] && (issue_op.rs1 != '0), regs[issue_op.rs1],
                       alias_tag[issue_op.rs1], lookup_opnd1);
        src2 = resolve(busy[issue_op.rs2] && (issue_op.rs2 != '0), regs[issue_op.rs2],
                       alias_tag[issue_op.rs2], lookup_opnd2);
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin
                regs[commit.rd] <= commit.value;
                // A younger rename keeps the register busy
                if (alias_tag[commit.rd] == commit_tag) begin
                    busy[commit.rd] <= 1'b0;
                end
            end
            // Issue comes last so a new alias beats a same-cycle retire
            if (issue_fire && issue_op.rd != '0) begin
                busy[issue_op.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (issue_fire && issue_op.rd != '0) begin
            alias_tag[issue_op.rd] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// File: alu_rs/alu_rs.sv
`default_nettype none

module alu_rs
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic             itf,
    input  logic             rst_n,
    input  logic             insert,
    input  alu_op_e          op,
    input  logic             use_imm,
    input  logic [xlen-1:0]  imm,
    input  logic [tag_w-1:0] dest_tag,
    input  operand_t         src1,
    input  operand_t         src2,
    input  cdb_t             cdb,
    input  logic             unit_busy,
    output logic             full,
    output exec_req_t        req
);

    logic [rs_depth-1:0] valid;
    // older[i][j] set means entry i was allocated before entry j
    logic [rs_depth-1:0] older [rs_depth];
    alu_op_e             e_op  [rs_depth];
    logic [tag_w-1:0]    e_tag [rs_depth];
    operand_t            e_a   [rs_depth];
    operand_t            e_b   [rs_depth];

    logic [rs_depth-1:0] rdy;
    logic [rs_depth-1:0] pick;
    logic [rs_depth-1:0] occupied;
    logic [rs_idx_w-1:0] sel_idx;
    logic [rs_idx_w-1:0] ins_idx;
    logic                fire;
    operand_t            ins_b;

    function automatic operand_t snoop(operand_t o, cdb_t c);
        operand_t r;
        r = o;
        if (!o.ready && c.valid && c.tag == o.tag) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            rdy[i] = valid[i] && e_a[i].ready && e_b[i].ready;
        end
    end

    // Only the oldest ready entry survives the age check
    always_comb begin
        for (int i = 0; i < rs_depth; i++) begin
            pick[i] = rdy[i];
            for (int j = 0; j < rs_depth; j++) begin
                if (rdy[j] && older[j][i]) begin
                    pick[i] = 1'b0;
                end
            end
        end
    end

    always_comb begin
        sel_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (pick[i]) begin
                sel_idx = rs_idx_w'(i);
            end
        end
    end

    assign fire = !unit_busy && (|pick);

    // The slot leaving this cycle is free for the incoming entry
    assign occupied = valid & ~({rs_depth{fire}} & pick);
    assign full     = &occupied;

    always_comb begin
        ins_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                ins_idx = rs_idx_w'(i);
            end
        end
    end

    always_comb begin
        ins_b = src2;
        if (use_imm) begin
            ins_b.ready = 1'b1;
            ins_b.tag   = '0;
            ins_b.value = imm;
        end
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            valid <= '0;
            req   <= '0;
        end else begin
            req.valid <= fire;
            req.op    <= e_op[sel_idx];
            req.tag   <= e_tag[sel_idx];
            req.a     <= e_a[sel_idx].value;
            req.b     <= e_b[sel_idx].value;
            if (fire) begin
                valid[sel_idx] <= 1'b0;
            end
            if (insert) begin
                valid[ins_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        for (int i = 0; i < rs_depth; i++) begin
            e_a[i] <= snoop(e_a[i], cdb);
            e_b[i] <= snoop(e_b[i], cdb);
        end
        if (insert) begin
            e_op[ins_idx]  <= op;
            e_tag[ins_idx] <= dest_tag;
            e_a[ins_idx]   <= snoop(src1, cdb);
            e_b[ins_idx]   <= snoop(ins_b, cdb);
            // New entry is younger than everything already held
            older[ins_idx] <= '0;
            for (int j = 0; j < rs_depth; j++) begin
                if (j != int'(ins_idx)) begin
                    older[j][ins_idx] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`default_nettype none

module reorder_buffer
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic                 itf,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  logic [reg_idx_w-1:0] alloc_rd,
    output logic [tag_w-1:0]     alloc_tag,
    output logic                 full,
    input  logic [tag_w-1:0]     lookup_tag1,
    input  logic [tag_w-1:0]     lookup_tag2,
    output operand_t             lookup_opnd1,
    output operand_t             lookup_opnd2,
    input  cdb_t                 cdb,
    output commit_t              commit,
    output logic [tag_w-1:0]     commit_tag
);

    logic [tag_w-1:0]     head;
    logic [tag_w-1:0]     tail;
    logic [tag_w:0]       count;
    logic [rob_depth-1:0] done;
    logic [reg_idx_w-1:0] e_rd    [rob_depth];
    logic [xlen-1:0]      e_value [rob_depth];
    logic                 retire;

    assign alloc_tag = tail;
    assign full      = (count == (tag_w + 1)'(rob_depth));
    assign retire    = (count != '0) && done[head];

    // Head retires in the cycle after its result is recorded
    assign commit.valid = retire;
    assign commit.rd    = e_rd[head];
    assign commit.value = e_value[head];
    assign commit_tag   = head;

    always_comb begin
        lookup_opnd1.ready = done[lookup_tag1];
        lookup_opnd1.tag   = lookup_tag1;
        lookup_opnd1.value = e_value[lookup_tag1];
        lookup_opnd2.ready = done[lookup_tag2];
        lookup_opnd2.tag   = lookup_tag2;
        lookup_opnd2.value = e_value[lookup_tag2];
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (retire) begin
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // Broadcast tags always name a live entry
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            count <= count + (tag_w + 1)'(alloc) - (tag_w + 1)'(retire);
        end
    end

    always_ff @(posedge itf) begin
        if (alloc) begin
            e_rd[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            e_value[cdb.tag] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
`default_nettype none

module alu_unit
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic      itf,
    input  logic      rst_n,
    input  exec_req_t req,
    output logic      busy,
    output cdb_t      cdb
);

    logic [mul_cnt_w-1:0] mul_cnt;
    logic [tag_w-1:0]     mul_tag;
    logic [xlen-1:0]      mul_a;
    logic [xlen-1:0]      mul_b;
    logic [xlen-1:0]      mul_prod;
    logic [xlen-1:0]      alu_res;
    logic                 take_mul;

    assign take_mul = req.valid && (req.op == alu_mul) && (mul_cnt == '0);

    // Busy from the cycle a multiply is presented until its last cycle
    assign busy = (mul_cnt != '0) || (req.valid && req.op == alu_mul);

    // Low half of the product only
    assign mul_prod = mul_a * mul_b;

    always_comb begin
        case (req.op)
            alu_add: alu_res = req.a + req.b;
            alu_sub: alu_res = req.a - req.b;
            alu_and: alu_res = req.a & req.b;
            alu_or:  alu_res = req.a | req.b;
            alu_xor: alu_res = req.a ^ req.b;
            alu_sll: alu_res = req.a << req.b[shamt_w-1:0];
            alu_srl: alu_res = req.a >> req.b[shamt_w-1:0];
            alu_slt: alu_res = {{(xlen - 1){1'b0}}, $signed(req.a) < $signed(req.b)};
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge itf) begin
        if (!rst_n) begin
            mul_cnt <= '0;
            cdb     <= '0;
        end else begin
            cdb.valid <= 1'b0;
            if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 1'b1;
                if (mul_cnt == mul_cnt_w'(1)) begin
                    cdb.valid <= 1'b1;
                    cdb.tag   <= mul_tag;
                    cdb.value <= mul_prod;
                end
            end else if (req.valid) begin
                if (req.op == alu_mul) begin
                    mul_cnt <= mul_cnt_w'(mul_cycles - 1);
                end else begin
                    cdb.valid <= 1'b1;
                    cdb.tag   <= req.tag;
                    cdb.value <= alu_res;
                end
            end
        end
    end

    always_ff @(posedge itf) begin
        if (take_mul) begin
            mul_tag <= req.tag;
            mul_a   <= req.a;
            mul_b   <= req.b;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ooo_core.sv
`default_nettype none

module ooo_core
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic      itf,
    input  logic      rst_n,
    input  logic      issue_valid,
    input  issue_op_t issue_op,
    output logic      issue_ready,
    output commit_t   commit
);

    logic             issue_fire;
    logic             rob_full;
    logic             rs_full;
    logic [tag_w-1:0] alloc_tag;
    logic [tag_w-1:0] lookup_tag1;
    logic [tag_w-1:0] lookup_tag2;
    logic [tag_w-1:0] commit_tag;
    operand_t         lookup_opnd1;
    operand_t         lookup_opnd2;
    operand_t         src1;
    operand_t         src2;
    cdb_t             cdb;
    exec_req_t        req;
    logic             unit_busy;

    // Both the ROB and the station must have a free slot
    assign issue_ready = !rob_full && !rs_full;
    assign issue_fire  = issue_valid && issue_ready;

    reg_alias_file u_raf (
        .itf          (itf),
        .rst_n        (rst_n),
        .issue_fire   (issue_fire),
        .issue_op     (issue_op),
        .alloc_tag    (alloc_tag),
        .lookup_tag1  (lookup_tag1),
        .lookup_tag2  (lookup_tag2),
        .lookup_opnd1 (lookup_opnd1),
        .lookup_opnd2 (lookup_opnd2),
        .src1         (src1),
        .src2         (src2),
        .commit       (commit),
        .commit_tag   (commit_tag)
    );

    alu_rs u_rs (
        .itf       (itf),
        .rst_n     (rst_n),
        .insert    (issue_fire),
        .op        (issue_op.op),
        .use_imm   (issue_op.use_imm),
        .imm       (issue_op.imm),
        .dest_tag  (alloc_tag),
        .src1      (src1),
        .src2      (src2),
        .cdb       (cdb),
        .unit_busy (unit_busy),
        .full      (rs_full),
        .req       (req)
    );

    alu_unit u_alu (
        .itf   (itf),
        .rst_n (rst_n),
        .req   (req),
        .busy  (unit_busy),
        .cdb   (cdb)
    );

    reorder_buffer u_rob (
        .itf          (itf),
        .rst_n        (rst_n),
        .alloc        (issue_fire),
        .alloc_rd     (issue_op.rd),
        .alloc_tag    (alloc_tag),
        .full         (rob_full),
        .lookup_tag1  (lookup_tag1),
        .lookup_tag2  (lookup_tag2),
        .lookup_opnd1 (lookup_opnd1),
        .lookup_opnd2 (lookup_opnd2),
        .cdb          (cdb),
        .commit       (commit),
        .commit_tag   (commit_tag)
    );

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic itf,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ns;

    localparam int half_period  = 50;
    localparam int reset_cycles = 16;

    initial begin
        itf = 1'b0;
        forever #(half_period) itf = ~itf;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge itf);
        @(negedge itf);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb
    import ooo_params_pkg::*;
    import ooo_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] ridx_t;

    localparam int wait_limit = 200;

    logic      itf;
    logic      rst_n;
    logic      issue_valid;
    issue_op_t issue_op;
    logic      issue_ready;
    commit_t   commit;

    // Reference register state updated in program order at issue
    word_t   model_regs [num_regs];
    commit_t exp_q [$];
    bit      mul_q [$];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int total_cycles;
    int stall_cycles;
    int commit_count;
    int mul_busy_cycles;
    int mul_pending;

    tb_clock u_clock (
        .itf   (itf),
        .rst_n (rst_n)
    );

    ooo_core u_dut (
        .itf         (itf),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_ready (issue_ready),
        .commit      (commit)
    );

    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << b[4:0];
            alu_srl: return a >> b[4:0];
            alu_slt: return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            alu_mul: return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic issue_op_t make_op(alu_op_e op, int rd, int rs1, int rs2,
                                          logic use_imm, word_t imm);
        issue_op_t o;
        o.op      = op;
        o.rd      = ridx_t'(rd);
        o.rs1     = ridx_t'(rs1);
        o.rs2     = ridx_t'(rs2);
        o.use_imm = use_imm;
        o.imm     = imm;
        return o;
    endfunction

    task automatic record_error();
        errors++;
        test_errors++;
    endtask

    // Holds the op until accepted, then steps to the next falling edge
    task automatic issue_one(input issue_op_t op, output int waited);
        commit_t exp;
        word_t   b;
        waited      = 0;
        issue_op    = op;
        issue_valid = 1'b1;
        while (!issue_ready && waited < wait_limit) begin
            @(negedge itf);
            waited++;
        end
        if (!issue_ready) begin
            $display("error at %0t: issue_ready stayed low for %0d cycles", $time, wait_limit);
            record_error();
            issue_valid = 1'b0;
        end else begin
            b         = op.use_imm ? op.imm : model_regs[op.rs2];
            exp.valid = 1'b1;
            exp.rd    = op.rd;
            exp.value = model_alu(op.op, model_regs[op.rs1], b);
            if (op.rd != '0) begin
                model_regs[op.rd] = exp.value;
            end
            exp_q.push_back(exp);
            mul_q.push_back(op.op == alu_mul);
            if (op.op == alu_mul) begin
                mul_pending++;
            end
            @(negedge itf);
        end
    endtask

    // The queue is looked at on rising edges, between the monitor's updates
    task automatic drain();
        int waited;
        waited      = 0;
        issue_valid = 1'b0;
        @(posedge itf);
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(posedge itf);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("error at %0t: %0d commits still missing after %0d cycles",
                     $time, exp_q.size(), wait_limit);
            record_error();
            exp_q.delete();
            mul_q.delete();
            mul_pending = 0;
        end
        @(negedge itf);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic idle_after_reset();
        assert (issue_ready) else begin
            $display("error at %0t: issue_ready low after reset", $time);
            record_error();
        end
        repeat (10) begin
            @(negedge itf);
            assert (!commit.valid) else begin
                $display("mismatch at %0t: commit.valid expected 0 got 1", $time);
                record_error();
            end
        end
        finish_test("reset_idle");
    endtask

    task automatic each_op_results();
        alu_op_e ops [9] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
                             alu_sll, alu_srl, alu_slt, alu_mul};
        int      base;
        int      waited;
        for (int k = 0; k < 9; k++) begin
            base = 1 + 3 * k;
            issue_one(make_op(alu_add, base, 0, 0, 1'b1, $urandom()), waited);
            issue_one(make_op(alu_add, base + 1, 0, 0, 1'b1, $urandom()), waited);
            issue_one(make_op(ops[k], base + 2, base, base + 1, 1'b0, '0), waited);
            issue_one(make_op(ops[k], base + 2, base, 0, 1'b1, $urandom()), waited);
        end
        // Write to x0, then read it back through an or
        issue_one(make_op(alu_add, 0, 1, 2, 1'b0, '0), waited);
        issue_one(make_op(alu_or, 30, 0, 1, 1'b0, '0), waited);
        drain();
        finish_test("each_op");
    endtask

    task automatic raw_chain_order();
        int waited;
        issue_one(make_op(alu_add, 1, 0, 0, 1'b1, $urandom()), waited);
        issue_one(make_op(alu_add, 2, 0, 0, 1'b1, $urandom()), waited);
        issue_one(make_op(alu_mul, 3, 1, 2, 1'b0, '0), waited);
        issue_one(make_op(alu_add, 4, 3, 1, 1'b0, '0), waited);
        for (int i = 5; i < 9; i++) begin
            issue_one(make_op(alu_add, i, 1, 0, 1'b1, word_t'(i)), waited);
        end
        drain();
        finish_test("raw_chain");
    endtask

    task automatic multiply_backpressure();
        int waited;
        int stalls;
        stalls = 0;
        issue_one(make_op(alu_add, 8, 0, 0, 1'b1, word_t'(3)), waited);
        for (int i = 0; i < 10; i++) begin
            issue_one(make_op(alu_mul, 8, 8, 0, 1'b1, word_t'(3)), waited);
            stalls += waited;
        end
        assert (stalls > 0) else begin
            $display("error at %0t: issue_ready never dropped in the multiply chain", $time);
            record_error();
        end
        drain();
        finish_test("backpressure");
    endtask

    task automatic random_stream();
        issue_op_t op;
        int        waited;
        for (int i = 0; i < 300; i++) begin
            op = make_op(alu_op_e'($urandom_range(0, 8)), $urandom_range(0, 31),
                         $urandom_range(0, 31), $urandom_range(0, 31),
                         $urandom_range(0, 1) == 1, $urandom());
            issue_one(op, waited);
            // Occasional bubble in the issue stream
            if ($urandom_range(0, 3) == 0) begin
                issue_valid = 1'b0;
                @(negedge itf);
            end
        end
        drain();
        assert (issue_ready) else begin
            $display("error at %0t: issue_ready low after the stream drained", $time);
            record_error();
        end
        repeat (20) begin
            @(negedge itf);
            assert (!commit.valid) else begin
                $display("mismatch at %0t: commit.valid expected 0 got 1", $time);
                record_error();
            end
        end
        finish_test("random_stream");
    endtask

    // Port-level profiling
    always @(posedge itf) begin : profiling
        if (rst_n) begin
            total_cycles++;
            if (issue_valid && !issue_ready) begin
                stall_cycles++;
            end
            if (mul_pending > 0) begin
                mul_busy_cycles++;
            end
        end
    end

    // Commit checker
    always @(negedge itf) begin : commit_monitor
        commit_t exp;
        bit      was_mul;
        if (rst_n) begin
            if (commit.valid) begin
                commit_count++;
                if (exp_q.size() == 0) begin
                    $display("error at %0t: commit to x%0d with nothing outstanding",
                             $time, commit.rd);
                    record_error();
                end else begin
                    exp     = exp_q.pop_front();
                    was_mul = mul_q.pop_front();
                    if (was_mul) begin
                        mul_pending--;
                    end
                    assert (commit.rd == exp.rd) else begin
                        $display("mismatch at %0t: commit.rd expected %0d got %0d",
                                 $time, exp.rd, commit.rd);
                        record_error();
                    end
                    assert (commit.value == exp.value) else begin
                        $display("mismatch at %0t: commit.value expected %h got %h",
                                 $time, exp.value, commit.value);
                        record_error();
                    end
                end
            end
        end
    end

    initial begin : main
        int waited;
        issue_valid = 1'b0;
        issue_op    = '0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'h958234a0));
        waited = 0;
        while (rst_n !== 1'b1 && waited < wait_limit) begin
            @(negedge itf);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("error at %0t: reset was never released", $time);
            record_error();
        end
        @(negedge itf);
        idle_after_reset();
        each_op_results();
        raw_chain_order();
        multiply_backpressure();
        random_stream();
        $display("profile: %0d cycles, %0d stall cycles, %0d commits, %0d multiply cycles",
                 total_cycles, stall_cycles, commit_count, mul_busy_cycles);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/ooo_params_pkg.sv
common/ooo_types_pkg.sv
verilog/reg_alias_file.sv
alu_rs/alu_rs.sv
rob/reorder_buffer.sv
verilog/alu_unit.sv
verilog/ooo_core.sv
test/tb_clock.sv
test/ooo_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module ooo_core_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vooo_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
    exit 0
fi
exit 1
